//--- Makefile
# Verilator build and run of the game control testbench
VERILATOR ?= verilator
TOP       ?= tb_game_top
RTL_TOP   ?= game_top
FILELIST  ?= kong_game.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- barrel_launcher.sv
// Barrel launcher with cooldown and a rotating barrel slot
// One instance per barrel direction
`timescale 1ns/100ps

module barrel_launcher
   import game_pkg::*;
#(
   parameter int DELAY = 100
) (
   input  logic    clk65MHz,
   input  logic    rst_n,
   input  logic    game_en,
   input  logic    key,
   output launch_t launch
);

   localparam int CW = $clog2(DELAY + 1);

   logic [CW-1:0] cooldown;
   slot_t         slot;

   always_ff @(posedge clk65MHz) begin
      if (!rst_n) begin
         cooldown <= '0;
         slot     <= '0;
         launch   <= '0;
      end else begin
         launch.valid <= 1'b0;
         if (cooldown != '0) begin
            cooldown <= cooldown - CW'(1);
         end
         // Presses during cooldown are dropped
         if (key && game_en && (cooldown == '0)) begin
            launch.valid <= 1'b1;
            launch.slot  <= slot;
            cooldown     <= CW'(DELAY);
            if (slot == slot_t'(BARRELS - 1)) begin
               slot <= '0;
            end else begin
               slot <= slot + slot_t'(1);
            end
         end
      end
   end

endmodule

//--- game_checker.sv
// Testbench checker for the game control path
// Runs a model of the game rules from the DUT ports and reports per test
`timescale 1ns/100ps

module game_checker
   import game_pkg::*, ps2_pkg::*;
#(
   parameter int HOR_DELAY = 400,
   parameter int VER_DELAY = 3,
   parameter int STEP      = 16
) (
   input  logic     clk65MHz,
   input  logic     rst_n,
   input  logic     ps2_clk,
   input  logic     ps2_data,
   input  hit_vec_t barrel_hit,
   input  logic     game_en,
   input  health_t  health,
   input  coord_t   xpos,
   input  launch_t  hor_launch,
   input  launch_t  ver_launch,
   input  int       test_id,
   output int       checks,
   output int       errors
);

   // Cycles after a frame or hit before the outputs must match the model
   localparam int SETTLE = 10;

   logic        m_en;
   health_t     m_health;
   coord_t      m_xpos;
   logic        m_break;
   logic [10:0] shift;
   int          nbits;
   logic        clk_last;
   int          cycle = 0;
   int          quiet;
   int          cur_test = 0;
   int          test_checks = 0;
   int          test_errs = 0;
   string       lname;
   int          last_launch [2];
   int          maybe_cnt [2];
   int          pend_time [2];
   logic        pending [2];
   slot_t       pend_slot [2];
   slot_t       m_slot [2];
   launch_t     seen [2];

   function automatic string test_name(int id);
      case (id)
         1: return "reset";
         2: return "start_hits";
         3: return "movement";
         4: return "hor_cooldown";
         5: return "ver_launch";
         6: return "rejected";
         default: return "idle";
      endcase
   endfunction

   function automatic slot_t next_slot(slot_t s);
      return slot_t'((int'(s) + 1) % BARRELS);
   endfunction

   task automatic compare(string what, int expected, int actual);
      checks++;
      test_checks++;
      if (expected != actual) begin
         errors++;
         test_errs++;
         $display("ERR %s %s expected %0d actual %0d", test_name(cur_test), what,
                  expected, actual);
      end
   endtask

   // Launcher i gets a press, index 0 is horizontal
   task automatic press_launch(int i);
      int gap;
      int delay;
      gap   = cycle - last_launch[i];
      delay = (i == 0) ? HOR_DELAY : VER_DELAY;
      if (m_en) begin
         if (gap >= delay) begin
            pending[i]   = 1'b1;
            pend_slot[i] = m_slot[i];
            pend_time[i] = cycle;
            m_slot[i]    = next_slot(m_slot[i]);
         end else if (gap >= delay - SETTLE) begin
            // Too close to the end of the cooldown to call either way
            maybe_cnt[i] = SETTLE;
         end
      end
   endtask

   task automatic apply_code(logic [7:0] code);
      int nx;
      if (code == SC_BREAK) begin
         m_break = 1'b1;
      end else if (m_break) begin
         m_break = 1'b0;
      end else begin
         case (code)
            SC_START: begin
               if (!m_en) begin
                  m_en     = 1'b1;
                  m_health = HEALTH_MAX;
               end
            end
            SC_LEFT: begin
               if (m_en) begin
                  nx     = int'(m_xpos) - STEP;
                  m_xpos = (nx < int'(X_MIN)) ? X_MIN : coord_t'(nx);
               end
            end
            SC_RIGHT: begin
               if (m_en) begin
                  nx     = int'(m_xpos) + STEP;
                  m_xpos = (nx > int'(X_MAX)) ? X_MAX : coord_t'(nx);
               end
            end
            SC_UP: begin
               press_launch(0);
            end
            SC_DOWN: begin
               press_launch(1);
            end
            default: begin
            end
         endcase
      end
   endtask

   always @(posedge clk65MHz) begin
      cycle++;
      seen[0] = hor_launch;
      seen[1] = ver_launch;
      if (test_id != cur_test) begin
         if (cur_test != 0) begin
            $display("test %s done, %0d checks, %0d errors", test_name(cur_test),
                     test_checks, test_errs);
         end
         cur_test    = test_id;
         test_checks = 0;
         test_errs   = 0;
      end
      if (!rst_n) begin
         m_en     = 1'b0;
         m_health = HEALTH_MAX;
         m_xpos   = X_START;
         m_break  = 1'b0;
         nbits    = 0;
         clk_last = 1'b1;
         quiet    = 0;
         checks   = 0;
         errors   = 0;
         for (int i = 0; i < 2; i++) begin
            last_launch[i] = -100000;
            maybe_cnt[i]   = 0;
            pending[i]     = 1'b0;
            m_slot[i]      = '0;
         end
      end else begin
         for (int i = 0; i < 2; i++) begin
            lname = (i == 0) ? "hor launch" : "ver launch";
            if (seen[i].valid) begin
               if (pending[i]) begin
                  compare({lname, " slot"}, int'(pend_slot[i]), int'(seen[i].slot));
                  pending[i] = 1'b0;
               end else if (maybe_cnt[i] > 0) begin
                  compare({lname, " slot"}, int'(m_slot[i]), int'(seen[i].slot));
                  m_slot[i]    = next_slot(m_slot[i]);
                  maybe_cnt[i] = 0;
               end else begin
                  compare({lname, " valid"}, 0, 1);
               end
               last_launch[i] = cycle;
            end else if (pending[i] && (cycle - pend_time[i] > SETTLE)) begin
               compare({lname, " valid"}, 1, 0);
               pending[i] = 1'b0;
            end
            if (maybe_cnt[i] > 0) begin
               maybe_cnt[i]--;
            end
         end
         if (barrel_hit != '0) begin
            quiet = 0;
            if (m_en) begin
               m_health = m_health - health_t'(1);
               if (m_health == health_t'(0)) begin
                  m_en   = 1'b0;
                  m_xpos = X_START;
               end
            end
         end
         // Bits arrive LSB first on falling ps2_clk
         if (clk_last && !ps2_clk) begin
            shift = {ps2_data, shift[10:1]};
            nbits++;
            if (nbits == 11) begin
               nbits = 0;
               quiet = 0;
               if (!shift[0] && shift[10] && (^shift[9:1])) begin
                  apply_code(shift[8:1]);
               end
            end
         end
         clk_last = ps2_clk;
         if (quiet <= SETTLE) begin
            quiet++;
         end
         if (quiet == SETTLE) begin
            compare("game_en", int'(m_en), int'(game_en));
            compare("health", int'(m_health), int'(health));
            compare("xpos", int'(m_xpos), int'(xpos));
         end
      end
   end

endmodule

//--- game_fsm.sv
// Game state machine with the player's life counter
// Start enters play, every cycle with a barrel hit in play costs a life
`timescale 1ns/100ps

module game_fsm
   import game_pkg::*;
(
   input  logic     clk65MHz,
   input  logic     rst_n,
   input  logic     start,
   input  hit_vec_t barrel_hit,
   output logic     game_en,
   output health_t  health
);

   game_state_t state;

   always_ff @(posedge clk65MHz) begin
      if (!rst_n) begin
         state  <= MENU;
         health <= HEALTH_MAX;
      end else begin
         case (state)
            MENU, OVER: begin
               if (start) begin
                  state  <= PLAY;
                  health <= HEALTH_MAX;
               end
            end
            PLAY: begin
               if (|barrel_hit) begin
                  health <= health - health_t'(1);
                  // Last life gone
                  if (health == health_t'(1)) begin
                     state <= OVER;
                  end
               end
            end
            default: begin
               state <= MENU;
            end
         endcase
      end
   end

   assign game_en = (state == PLAY);

endmodule

//--- game_pkg.sv
// Game-level types and constants shared by the execute modules
// Covers the play field, health and the two barrel launchers

package game_pkg;

   // Screen x coordinate of the player
   typedef logic [10:0] coord_t;

   localparam coord_t X_MIN   = 11'd0;
   localparam coord_t X_MAX   = 11'd976;
   localparam coord_t X_START = 11'd64;

   // Barrels handled by each launcher
   localparam int BARRELS = 5;

   typedef logic [2:0] slot_t;

   // Low half is the horizontal launcher, high half the vertical one
   typedef logic [2*BARRELS-1:0] hit_vec_t;

   typedef logic [1:0] health_t;

   localparam health_t HEALTH_MAX = 2'd3;

   typedef enum logic [1:0] {
      MENU = 2'd0,
      PLAY = 2'd1,
      OVER = 2'd2
   } game_state_t;

   // One launch event, slot is only meaningful while valid is high
   typedef struct packed {
      logic  valid;
      slot_t slot;
   } launch_t;

endpackage

//--- game_top.sv
// Top level of the game control path
// Keyboard decode feeds the game FSM, player movement and both launchers
`timescale 1ns/100ps

module game_top
   import game_pkg::*, ps2_pkg::*;
#(
   parameter int HOR_DELAY = 162_500_000,
   parameter int VER_DELAY = 20_500_000,
   parameter int STEP      = 16
) (
   input  logic     clk65MHz,
   input  logic     rst_n,
   input  logic     ps2_clk,
   input  logic     ps2_data,
   input  hit_vec_t barrel_hit,
   output logic     game_en,
   output health_t  health,
   output coord_t   xpos,
   output launch_t  hor_launch,
   output launch_t  ver_launch
);

   logic [7:0] scan_byte;
   logic       scan_valid;
   key_press_t press;

   // Keyboard
   ps2_frame_rx u_ps2_frame_rx (
      .clk65MHz,
      .rst_n,
      .ps2_clk,
      .ps2_data,
      .scan_byte,
      .scan_valid
   );

   key_decoder u_key_decoder (
      .clk65MHz,
      .rst_n,
      .scan_byte,
      .scan_valid,
      .press
   );

   // Game control
   game_fsm u_game_fsm (
      .clk65MHz,
      .rst_n,
      .start(press.start),
      .barrel_hit,
      .game_en,
      .health
   );

   player_movement #(
      .STEP(STEP)
   ) u_player_movement (
      .clk65MHz,
      .rst_n,
      .game_en,
      .left(press.left),
      .right(press.right),
      .xpos
   );

   barrel_launcher #(
      .DELAY(HOR_DELAY)
   ) u_hor_launcher (
      .clk65MHz,
      .rst_n,
      .game_en,
      .key(press.up),
      .launch(hor_launch)
   );

   barrel_launcher #(
      .DELAY(VER_DELAY)
   ) u_ver_launcher (
      .clk65MHz,
      .rst_n,
      .game_en,
      .key(press.down),
      .launch(ver_launch)
   );

endmodule

//--- key_decoder.sv
// Scan byte to key press decoder
// A break prefix swallows the following code, so releases give no press
`timescale 1ns/100ps

module key_decoder
   import ps2_pkg::*;
(
   input  logic       clk65MHz,
   input  logic       rst_n,
   input  logic [7:0] scan_byte,
   input  logic       scan_valid,
   output key_press_t press
);

   logic break_pending;

   always_ff @(posedge clk65MHz) begin
      if (!rst_n) begin
         break_pending <= 1'b0;
         press         <= '0;
      end else begin
         press <= '0;
         if (scan_valid) begin
            if (scan_byte == SC_BREAK) begin
               break_pending <= 1'b1;
            end else if (break_pending) begin
               // Code of the released key
               break_pending <= 1'b0;
            end else begin
               case (scan_byte)
                  SC_LEFT: begin
                     press.left <= 1'b1;
                  end
                  SC_RIGHT: begin
                     press.right <= 1'b1;
                  end
                  SC_UP: begin
                     press.up <= 1'b1;
                  end
                  SC_DOWN: begin
                     press.down <= 1'b1;
                  end
                  SC_START: begin
                     press.start <= 1'b1;
                  end
                  default: begin
                     press <= '0;
                  end
               endcase
            end
         end
      end
   end

endmodule

//--- kong_game.f
game_pkg.sv
ps2_pkg.sv
ps2_frame_rx.sv
key_decoder.sv
game_fsm.sv
player_movement.sv
barrel_launcher.sv
game_top.sv
game_checker.sv
tb_game_top.sv

//--- player_movement.sv
// Horizontal position of player one
// Steps on each left or right press during play, clamped to the field
`timescale 1ns/100ps

module player_movement
   import game_pkg::*;
#(
   parameter int STEP = 16
) (
   input  logic   clk65MHz,
   input  logic   rst_n,
   input  logic   game_en,
   input  logic   left,
   input  logic   right,
   output coord_t xpos
);

   always_ff @(posedge clk65MHz) begin
      if (!rst_n) begin
         xpos <= X_START;
      end else if (!game_en) begin
         xpos <= X_START;
      end else if (left) begin
         if (xpos < X_MIN + coord_t'(STEP)) begin
            xpos <= X_MIN;
         end else begin
            xpos <= xpos - coord_t'(STEP);
         end
      end else if (right) begin
         if (xpos > X_MAX - coord_t'(STEP)) begin
            xpos <= X_MAX;
         end else begin
            xpos <= xpos + coord_t'(STEP);
         end
      end
   end

endmodule

//--- ps2_frame_rx.sv
// PS/2 keyboard frame receiver
// Delivers one checked scan byte per frame with a single-cycle strobe
`timescale 1ns/100ps

module ps2_frame_rx
   import ps2_pkg::*;
(
   input  logic       clk65MHz,
   input  logic       rst_n,
   input  logic       ps2_clk,
   input  logic       ps2_data,
   output logic [7:0] scan_byte,
   output logic       scan_valid
);

   logic [1:0] clk_sync;
   logic [1:0] data_sync;
   logic       clk_prev;
   logic       fall;
   logic [3:0] bit_cnt;
   logic       frame_ok;
   ps2_frame_u frame;
   ps2_frame_u frame_next;

   // Both lines idle high
   always_ff @(posedge clk65MHz) begin
      if (!rst_n) begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_prev  <= clk_sync[1];
      end
   end

   assign fall = clk_prev & ~clk_sync[1];

   // LSB first on the wire, so the start bit settles at bit 0
   assign frame_next = {data_sync[1], frame.raw[10:1]};

   // Odd parity over data plus parity bit
   assign frame_ok = (frame_next.fields.start == 1'b0) &&
                     (frame_next.fields.stop == 1'b1) &&
                     (^{frame_next.fields.data, frame_next.fields.parity} == 1'b1);

   always_ff @(posedge clk65MHz) begin
      if (!rst_n) begin
         bit_cnt    <= 4'd0;
         scan_valid <= 1'b0;
      end else begin
         scan_valid <= 1'b0;
         if (fall) begin
            if (bit_cnt == 4'd10) begin
               bit_cnt    <= 4'd0;
               scan_valid <= frame_ok;
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
            end
         end
      end
   end

   always_ff @(posedge clk65MHz) begin
      if (fall) begin
         frame <= frame_next;
         if (bit_cnt == 4'd10) begin
            scan_byte <= frame_next.fields.data;
         end
      end
   end

endmodule

//--- ps2_pkg.sv
// Keyboard-side definitions: PS/2 frame layout, scan codes and key pulses
// Used by the frame receiver, the key decoder and the top level

package ps2_pkg;

   // Frame as it sits in the shift register once all eleven bits are in
   typedef struct packed {
      logic       stop;
      logic       parity;
      logic [7:0] data;
      logic       start;
   } ps2_fields_t;

   typedef union packed {
      logic [10:0] raw;
      ps2_fields_t fields;
   } ps2_frame_u;

   localparam logic [7:0] SC_LEFT  = 8'h1C;
   localparam logic [7:0] SC_RIGHT = 8'h23;
   localparam logic [7:0] SC_UP    = 8'h1D;
   localparam logic [7:0] SC_DOWN  = 8'h1B;
   localparam logic [7:0] SC_START = 8'h5A;

   // Prefix of a key release
   localparam logic [7:0] SC_BREAK = 8'hF0;

   // Single-cycle press pulses
   typedef struct packed {
      logic left;
      logic right;
      logic up;
      logic down;
      logic start;
   } key_press_t;

endpackage

//--- tb_game_top.sv
// Testbench for the game control path with random PS/2 frames and hits
// Comparing against the model happens in the game_checker instance
`timescale 1ns/100ps

module tb_game_top
   import game_pkg::*, ps2_pkg::*;
();

   localparam int HOR_DELAY = 400;
   localparam int VER_DELAY = 3;
   localparam int STEP      = 16;

   logic       clk65MHz;
   logic       rst_n;
   logic       ps2_clk;
   logic       ps2_data;
   hit_vec_t   barrel_hit;
   logic       game_en;
   health_t    health;
   coord_t     xpos;
   launch_t    hor_launch;
   launch_t    ver_launch;
   int         test_id;
   int         checks;
   int         errors;
   int         timeouts;
   integer     seed;
   logic [7:0] keys [5] = '{SC_LEFT, SC_RIGHT, SC_UP, SC_DOWN, SC_START};

   game_top #(
      .HOR_DELAY(HOR_DELAY),
      .VER_DELAY(VER_DELAY),
      .STEP(STEP)
   ) dut (.*);

   game_checker #(
      .HOR_DELAY(HOR_DELAY),
      .VER_DELAY(VER_DELAY),
      .STEP(STEP)
   ) u_checker (.*);

   initial begin
      clk65MHz = 1'b0;
      forever #20 clk65MHz = ~clk65MHz;
   end

   // Returns 1 ns after the n-th rising edge
   task automatic tick(int n);
      repeat (n) @(posedge clk65MHz);
      #1;
   endtask

   function automatic int rand_range(int lo, int hi);
      return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   task automatic send_frame(logic [7:0] code, logic bad_parity, logic bad_stop);
      logic [10:0] bits;
      bits = {~bad_stop, ~(^code) ^ bad_parity, code, 1'b0};
      for (int i = 0; i < 11; i++) begin
         ps2_data = bits[i];
         tick(4);
         ps2_clk = 1'b0;
         tick(4);
         ps2_clk = 1'b1;
      end
      ps2_data = 1'b1;
      tick(rand_range(12, 24));
   endtask

   task automatic wait_game_en(logic level);
      int n;
      n = 0;
      while (game_en !== level && n < 50) begin
         tick(1);
         n++;
      end
      if (game_en !== level) begin
         timeouts++;
         $display("Timeout: game_en did not go to %0d within 50 cycles", level);
      end
   endtask

   task automatic hit_pulse();
      tick(rand_range(5, 40));
      barrel_hit = hit_vec_t'($random(seed));
      if (barrel_hit == '0) begin
         barrel_hit = hit_vec_t'(1);
      end
      tick(1);
      barrel_hit = '0;
   endtask

   initial begin
      seed       = 32'h0c14bb15;
      rst_n      = 1'b0;
      ps2_clk    = 1'b1;
      ps2_data   = 1'b1;
      barrel_hit = '0;
      test_id    = 0;
      timeouts   = 0;
      tick(10);
      rst_n = 1'b1;

      // Menu ignores movement and launch keys
      test_id = 1;
      tick(20);
      for (int i = 0; i < 4; i++) begin
         send_frame(keys[i], 1'b0, 1'b0);
      end

      test_id = 2;
      send_frame(SC_START, 1'b0, 1'b0);
      wait_game_en(1'b1);
      repeat (3) hit_pulse();
      wait_game_en(1'b0);
      tick(15);
      send_frame(SC_START, 1'b0, 1'b0);
      wait_game_en(1'b1);

      // Left first to reach the left edge, then mostly right
      test_id = 3;
      for (int i = 0; i < 100; i++) begin
         if (i < 12) begin
            send_frame((rand_range(0, 7) == 0) ? SC_RIGHT : SC_LEFT, 1'b0, 1'b0);
         end else begin
            send_frame((rand_range(0, 15) == 0) ? SC_LEFT : SC_RIGHT, 1'b0, 1'b0);
         end
      end

      test_id = 4;
      repeat (30) send_frame(SC_UP, 1'b0, 1'b0);

      test_id = 5;
      repeat (12) send_frame(SC_DOWN, 1'b0, 1'b0);

      test_id = 6;
      for (int i = 0; i < 24; i++) begin
         case (rand_range(0, 2))
            0: begin
               send_frame(keys[rand_range(0, 4)], 1'b1, 1'b0);
            end
            1: begin
               send_frame(keys[rand_range(0, 4)], 1'b0, 1'b1);
            end
            default: begin
               send_frame(SC_BREAK, 1'b0, 1'b0);
               send_frame(keys[rand_range(0, 4)], 1'b0, 1'b0);
            end
         endcase
      end

      test_id = 0;
      tick(2);
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0 && checks > 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
